// ==== tcb_vectors.txt ====
// gap_cmd_adr_ben_wdt_rdt_err, gap is idle cycles before the request
// cmd 0 read 1 write, rdt and err are the expected response
2_1_0000_f_11223344_00000000_0
0_0_0000_0_00000000_11223344_0
0_1_0004_f_a5a5a5a5_00000000_0
0_1_0004_3_0000beef_00000000_0
0_0_0004_0_00000000_a5a5beef_0
0_1_0000_5_00cc00dd_00000000_0
0_0_0000_0_00000000_11cc33dd_0
3_1_1000_f_cafef00d_00000000_0
0_0_0000_0_00000000_11cc33dd_0
0_0_1000_0_00000000_cafef00d_0
0_1_03fc_f_0badc0de_00000000_0
0_0_03fc_0_00000000_0badc0de_0
4_0_0800_0_00000000_00000000_1
0_1_0800_f_deadbeef_00000000_1
0_1_2000_f_deadbeef_00000000_1
0_0_0000_0_00000000_11cc33dd_0
0_0_2000_0_00000000_00000000_1
1_1_1004_f_01020304_00000000_0
0_0_fffc_0_00000000_00000000_1
0_1_1004_c_77660000_00000000_0
0_0_0004_0_00000000_a5a5beef_0
0_0_1004_0_00000000_77660304_0
0_0_03fc_0_00000000_0badc0de_0

// ==== filelist.f ====
tcb_pkg.sv
tcb_lib_decoder.sv
tcb_lib_demultiplexer.sv
tcb_lib_multiplexer.sv
tcb_lib_sram.sv
tcb_interconnect_top.sv
tb_tcb_interconnect.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_tcb_interconnect
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_tcb_interconnect.sv ====
// testbench for the TCB interconnect, replays tcb_vectors.txt on the manager port
// and checks each response for read data, error flag and one cycle latency

module tb_tcb_interconnect;

  timeunit 1ns;
  timeprecision 1ps;

  // lines in the vector file
  localparam int unsigned NUM_VEC = 23;
  // cycles allowed for the last responses to come back
  localparam int unsigned TIMEOUT = 50;

  // one vector line, every field nibble aligned
  typedef struct packed {
    logic [3:0]                    gap;
    logic [3:0]                    cmd;
    logic [tcb_pkg::TCB_ADR_W-1:0] adr;
    logic [tcb_pkg::TCB_BEN_W-1:0] ben;
    logic [tcb_pkg::TCB_DAT_W-1:0] wdt;
    logic [tcb_pkg::TCB_DAT_W-1:0] rdt;
    logic [3:0]                    err;
  } vec_t;

  // response the DUT still owes
  typedef struct packed {
    logic [7:0]        idx;
    logic [31:0]       cyc;
    tcb_pkg::tcb_rsp_t rsp;
  } exp_t;

  logic              clk = 1'b0;
  logic              reset;
  logic              req_vld;
  tcb_pkg::tcb_req_t req;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  logic [$bits(vec_t)-1:0] vecs [NUM_VEC];
  exp_t                    exp_q [$];
  // rising edges seen so far
  int unsigned             cyc = 0;
  int                      seed = 47885;

  tcb_interconnect_top u_tcb_interconnect_top (
    .clk     (clk),
    .reset   (reset),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // 8 ns period
  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one request on the falling edge, expected response queued
  task automatic drive_vector(input vec_t v, input int unsigned idx);
    exp_t e;
    req_vld = 1'b0;
    repeat (v.gap) @(negedge clk);
    req_vld = 1'b1;
    req.cmd = tcb_pkg::tcb_cmd_t'(v.cmd[0]);
    req.adr = v.adr;
    req.ben = v.ben;
    // reads must ignore write data
    req.wdt = v.cmd[0] ? v.wdt : $random(seed);
    e.idx   = 8'(idx);
    e.cyc   = cyc;
    e.rsp   = '{rdt: v.rdt, err: v.err[0]};
    exp_q.push_back(e);
    @(negedge clk);
  endtask

////////////////////////////////////////////////////////////////////////////
// response monitor
////////////////////////////////////////////////////////////////////////////

  // sampled before the DUT registers update on this edge
  always @(posedge clk) begin
    exp_t e;
    if (!reset && rsp_vld !== 1'b0) begin
      if (exp_q.size() == 0) begin
        $display("response seen with no request outstanding at cycle %0d", cyc);
        $display("STATUS: FAIL");
        $fatal(1, "unexpected response");
      end else begin
        e = exp_q.pop_front();
        check_value($sformatf("vector %0d latency", e.idx), 64'd1, 64'(cyc - e.cyc));
        check_value($sformatf("vector %0d rdt", e.idx), 64'(e.rsp.rdt), 64'(rsp.rdt));
        check_value($sformatf("vector %0d err", e.idx), 64'(e.rsp.err), 64'(rsp.err));
      end
    end
    cyc = cyc + 1;
  end

////////////////////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned n;
    reset   = 1'b1;
    // read held through reset, reset must swallow it
    req_vld = 1'b1;
    req     = '0;
    $readmemh("tcb_vectors.txt", vecs);
    if ($isunknown(vecs[NUM_VEC-1])) begin
      $display("vector file holds fewer than %0d lines", NUM_VEC);
      $display("STATUS: FAIL");
      $fatal(1, "vector file incomplete");
    end
    // reset over 4 rising edges
    repeat (4) @(negedge clk);
    reset   = 1'b0;
    req_vld = 1'b0;
    // no response before the first request
    repeat (3) begin
      check_value("idle after reset", 64'd0, 64'(rsp_vld));
      @(negedge clk);
    end
    for (int i = 0; i < NUM_VEC; i++) begin
      drive_vector(vecs[i], i);
    end
    req_vld = 1'b0;
    // drain the outstanding responses
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d responses still missing after %0d cycles", exp_q.size(), TIMEOUT);
      $display("STATUS: FAIL");
      $fatal(1, "drain timeout");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== tcb_interconnect_top.sv ====
// TCB interconnect, one manager port over a fixed map of SRAM subordinates
// answers every request one cycle later, unmapped addresses return err

module tcb_interconnect_top #(
  // number of subordinates
  parameter  int unsigned MPN = 2,
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1,
  // address map, 1 KB regions at 0x0000 and 0x1000
  parameter  logic [tcb_pkg::TCB_ADR_W-1:0] DAM [MPN-1:0] = '{
    0: 16'b0000_00xx_xxxx_xxxx,
    1: 16'b0001_00xx_xxxx_xxxx
  },
  // words per SRAM
  parameter  int unsigned MEM_DEPTH = 256
)(
  input  logic              clk,
  input  logic              reset,
  // manager request
  input  logic              req_vld,
  input  tcb_pkg::tcb_req_t req,
  // manager response
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

////////////////////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////////////////////

  // decoder result
  logic [MPL-1:0]    sel;
  logic              hit;
  // subordinate strobes and responses
  logic [MPN-1:0]    sub_vld;
  tcb_pkg::tcb_rsp_t sub_rsp [MPN-1:0];
  // response owed in the next cycle
  logic              pnd_vld;
  logic              pnd_miss;
  logic [MPL-1:0]    pnd_sel;

////////////////////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////////////////////

  tcb_lib_decoder #(
    .MPN (MPN),
    .DAM (DAM)
  ) u_decoder (
    .req (req),
    .sel (sel),
    .hit (hit)
  );

  tcb_lib_demultiplexer #(
    .MPN (MPN)
  ) u_demultiplexer (
    .clk      (clk),
    .reset    (reset),
    .req_vld  (req_vld),
    .hit      (hit),
    .sel      (sel),
    .sub_vld  (sub_vld),
    .pnd_vld  (pnd_vld),
    .pnd_miss (pnd_miss),
    .pnd_sel  (pnd_sel)
  );

  // request payload is shared, only the strobe differs
  generate
    for (genvar i = 0; i < MPN; i++) begin : g_sram
      tcb_lib_sram #(
        .MEM_DEPTH (MEM_DEPTH)
      ) u_sram (
        .clk (clk),
        .vld (sub_vld[i]),
        .req (req),
        .rsp (sub_rsp[i])
      );
    end
  endgenerate

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

  tcb_lib_multiplexer #(
    .MPN (MPN)
  ) u_multiplexer (
    .pnd_vld  (pnd_vld),
    .pnd_miss (pnd_miss),
    .pnd_sel  (pnd_sel),
    .sub_rsp  (sub_rsp),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp)
  );

endmodule

// ==== tcb_lib_sram.sv ====
// single port SRAM subordinate with byte enables
// accepts a request every cycle, response data is registered

module tcb_lib_sram #(
  // words of TCB_DAT_W bits
  parameter  int unsigned MEM_DEPTH = 256,
  localparam int unsigned WAW = $clog2(MEM_DEPTH)
)(
  input  logic              clk,
  // request strobe from the demultiplexer
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp
);

  // byte offset bits below the word index
  localparam int unsigned BOW = $clog2(tcb_pkg::TCB_BEN_W);
  // one extra bit so an access past the end is visible
  localparam int unsigned IDX_W = WAW + 1;

////////////////////////////////////////////////////////////////////////////
// storage
////////////////////////////////////////////////////////////////////////////

  logic [tcb_pkg::TCB_DAT_W-1:0] mem [MEM_DEPTH];

  // word index inside the region
  logic [IDX_W-1:0] idx;

  // registered read data
  logic [tcb_pkg::TCB_DAT_W-1:0] rdt;

  assign idx = req.adr[BOW+IDX_W-1:BOW];

////////////////////////////////////////////////////////////////////////////
// access
////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (vld) begin
      if (req.cmd == tcb_pkg::TCB_WR) begin
        // enabled bytes only, the rest keep old contents
        for (int b = 0; b < tcb_pkg::TCB_BEN_W; b++) begin
          if (req.ben[b]) begin
            mem[idx[WAW-1:0]][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
        // writes answer with zero data
        rdt <= '0;
      end else begin
        rdt <= mem[idx[WAW-1:0]];
      end
    end
  end

  // never flags an error, misses are handled upstream
  assign rsp = '{
    rdt: rdt,
    err: 1'b0
  };

////////////////////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////////////////////

  // address map region must not be larger than the memory
  a_idx_range: assert property (@(posedge clk)
    vld |-> (idx < MEM_DEPTH));

endmodule

// ==== tcb_lib_multiplexer.sv ====
// response multiplexer, returns the owed subordinate response
// or an error response when the request matched no subordinate

module tcb_lib_multiplexer #(
  parameter  int unsigned MPN = 2,
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1
)(
  // pending response from the demultiplexer
  input  logic              pnd_vld,
  input  logic              pnd_miss,
  input  logic [MPL-1:0]    pnd_sel,
  // responses from all subordinates
  input  tcb_pkg::tcb_rsp_t sub_rsp [MPN-1:0],
  // manager side
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

////////////////////////////////////////////////////////////////////////////
// response select
////////////////////////////////////////////////////////////////////////////

  // strobe follows the pending flag directly
  assign rsp_vld = pnd_vld;

  // miss overrides whatever the selected subordinate drives
  always_comb begin
    if (pnd_miss) begin
      rsp = tcb_pkg::TCB_RSP_ERR;
    end else begin
      rsp = sub_rsp[pnd_sel];
    end
  end

////////////////////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////////////////////

  // hit responses must point at an existing subordinate
  always_comb begin
    if (pnd_vld && !pnd_miss) begin
      a_pnd_sel_range: assert (int'(pnd_sel) < MPN);
    end
  end

endmodule

// ==== tcb_lib_demultiplexer.sv ====
// request demultiplexer, steers the strobe to the decoded subordinate
// and remembers who owes the response in the next cycle

module tcb_lib_demultiplexer #(
  parameter  int unsigned MPN = 2,
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1
)(
  input  logic           clk,
  input  logic           reset,
  // request side
  input  logic           req_vld,
  input  logic           hit,
  input  logic [MPL-1:0] sel,
  // one strobe per subordinate
  output logic [MPN-1:0] sub_vld,
  // pending response
  output logic           pnd_vld,
  output logic           pnd_miss,
  output logic [MPL-1:0] pnd_sel
);

////////////////////////////////////////////////////////////////////////////
// strobe routing
////////////////////////////////////////////////////////////////////////////

  // misses go nowhere
  always_comb begin
    sub_vld = '0;
    if (req_vld && hit) begin
      sub_vld[sel] = 1'b1;
    end
  end

////////////////////////////////////////////////////////////////////////////
// pending response
////////////////////////////////////////////////////////////////////////////

  // one request in flight, replaced every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pnd_vld  <= 1'b0;
      pnd_miss <= 1'b0;
      pnd_sel  <= '0;
    end else begin
      pnd_vld  <= req_vld;
      pnd_miss <= req_vld & ~hit;
      pnd_sel  <= sel;
    end
  end

  // at most one subordinate sees a request
  a_sub_vld_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(sub_vld));

endmodule

// ==== tcb_lib_decoder.sv ====
// address decoder, matches the request address against a wildcard table
// x bits in a table entry are don't care, lowest matching index wins

module tcb_lib_decoder #(
  // number of subordinates
  parameter  int unsigned MPN = 2,
  localparam int unsigned MPL = (MPN > 1) ? $clog2(MPN) : 1,
  // address pattern per subordinate
  parameter  logic [tcb_pkg::TCB_ADR_W-1:0] DAM [MPN-1:0] = '{default: '0}
)(
  input  tcb_pkg::tcb_req_t req,
  output logic [MPL-1:0]    sel,
  output logic              hit
);

////////////////////////////////////////////////////////////////////////////
// match
////////////////////////////////////////////////////////////////////////////

  // one bit per table entry
  logic [MPN-1:0] mch;

  generate
    for (genvar i = 0; i < MPN; i++) begin : g_mch
      // wildcard compare, x in the pattern skips that bit
      assign mch[i] = (req.adr ==? DAM[i]);
    end
  endgenerate

////////////////////////////////////////////////////////////////////////////
// encode
////////////////////////////////////////////////////////////////////////////

  // walk down so the lowest index is written last
  always_comb begin
    // don't care when nothing matches
    sel = '0;
    for (int i = MPN - 1; i >= 0; i--) begin
      if (mch[i]) begin
        sel = MPL'(i);
      end
    end
  end

  assign hit = |mch;

endmodule

// ==== tcb_pkg.sv ====
// shared definitions for the TCB interconnect
// widths, bus command and request/response structs used by every block

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned TCB_ADR_W = 16;
  // data bus
  localparam int unsigned TCB_DAT_W = 32;
  // one enable per data byte
  localparam int unsigned TCB_BEN_W = TCB_DAT_W / 8;

  ////////////////////////////////////////////////////////////////////////////
  // command
  ////////////////////////////////////////////////////////////////////////////

  // single bit, read is the zero encoding
  typedef enum logic {
    TCB_RD = 1'b0,
    TCB_WR = 1'b1
  } tcb_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////////////////////

  // manager to subordinate, 53 bits
  typedef struct packed {
    // read or write
    tcb_cmd_t               cmd;
    // byte address
    logic [TCB_ADR_W-1:0]   adr;
    // byte enables, bit n covers wdt[8n+7:8n]
    logic [TCB_BEN_W-1:0]   ben;
    // write data, ignored on reads
    logic [TCB_DAT_W-1:0]   wdt;
  } tcb_req_t;

  // subordinate to manager, 33 bits
  typedef struct packed {
    // read data, zero on writes and misses
    logic [TCB_DAT_W-1:0]   rdt;
    // set when no subordinate covers the address
    logic                   err;
  } tcb_rsp_t;

  // response used for unmapped accesses
  localparam tcb_rsp_t TCB_RSP_ERR = '{
    rdt: '0,
    err: 1'b1
  };

endpackage
